//--- bus_pkg.sv
////////////////////
// Core side of the peripheral bus. Access codes are active-low sizes,
// so all ones means no access. The 11-bit address is seen either as
// 64-byte full slots or as 16-byte byte slots.
////////////////////
package bus_pkg;

    localparam int unsigned ADDR_W = 11;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned BYTE_W = 8;

    // Encoded size of a read or write strobe
    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,
        ACC_HALF = 2'b01,
        ACC_WORD = 2'b10,
        ACC_NONE = 2'b11
    } access_n_t;

    // Top two address bits of the byte-interface region
    localparam logic [1:0] REGION_BYTE = 2'b10;

    typedef union packed {
        struct packed {
            logic [4:0] slot;
            logic [5:0] offset;
        } full_v;
        struct packed {
            logic [2:0] region;
            logic [3:0] slot;
            logic [3:0] offset;
        } byte_v;
    } periph_addr_u;

    typedef struct packed {
        periph_addr_u        addr;
        logic [DATA_W-1:0]   wdata;
        access_n_t           write_n;
        access_n_t           read_n;
    } bus_req_t;

endpackage

//--- byte_reg_bank.sv
////////////////////
// Sixteen byte slots, one register each. The offset within a slot is
// ignored, so every address in the slot hits the same register.
////////////////////
`timescale 1ns/1ns

module byte_reg_bank (
    input  logic                                                        clk,
    input  logic                                                        rst_n,
    input  logic [periph_pkg::N_BYTE_SLOTS-1:0]                         i_sel,
    input  bus_pkg::bus_req_t                                           i_req,
    output logic [periph_pkg::N_BYTE_SLOTS-1:0][bus_pkg::BYTE_W-1:0]    o_rdata,
    output logic [periph_pkg::N_BYTE_SLOTS-1:0][periph_pkg::N_PINS-1:0] o_pins
);
    import bus_pkg::*;
    import periph_pkg::*;

    logic [N_BYTE_SLOTS-1:0][BYTE_W-1:0] regs;
    logic                                wr_en;

    assign wr_en = (i_req.write_n != ACC_NONE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '0;
        end else begin
            for (int k = 0; k < N_BYTE_SLOTS; k++) begin
                if (wr_en && i_sel[k]) begin
                    regs[k] <= i_req.wdata[BYTE_W-1:0];
                end
            end
        end
    end

    // The register is both readback and the slot's pin vector
    assign o_rdata = regs;
    assign o_pins  = regs;

endmodule

//--- gpio_ctrl.sv
////////////////////
// GPIO block in full slot 1. Only the low 8 bits of the output register
// exist. Each pin's function select routes it to any slot's pin vector;
// all pins reset to GPIO.
////////////////////
`timescale 1ns/1ns

module gpio_ctrl (
    input  logic                                                     clk,
    input  logic                                                     rst_n,
    input  logic                                                     i_sel,
    input  bus_pkg::bus_req_t                                        i_req,
    input  logic [periph_pkg::N_PINS-1:0]                            i_ui_in,
    input  logic [periph_pkg::N_BYTE_SLOTS-1:0][periph_pkg::N_PINS-1:0] i_byte_pins,
    output logic [bus_pkg::DATA_W-1:0]                               o_rdata,
    output logic [periph_pkg::N_PINS-1:0]                            o_uo_out
);
    import bus_pkg::*;
    import periph_pkg::*;

    localparam int unsigned SEL_W = $bits(func_sel_t);

    logic [N_PINS-1:0]            gpio_out;
    func_sel_t [N_PINS-1:0]       func_sel;
    logic [5:0]                   offset;
    logic                         wr_en;
    logic                         is_sel_reg;
    logic [$clog2(N_PINS)-1:0]    pin_idx;

    assign offset     = i_req.addr.full_v.offset;
    assign wr_en      = i_sel && (i_req.write_n != ACC_NONE);
    assign is_sel_reg = ((offset & GPIO_SEL_MASK) == GPIO_OFS_SEL);
    assign pin_idx    = offset[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
            func_sel <= {N_PINS{FUNC_SEL_GPIO}};
        end else if (wr_en) begin
            if (offset == GPIO_OFS_OUT) begin
                gpio_out <= i_req.wdata[N_PINS-1:0];
            end
            if (is_sel_reg) begin
                func_sel[pin_idx] <= func_sel_t'(i_req.wdata[SEL_W-1:0]);
            end
        end
    end

    // Readback, qualified by the decoder's select downstream
    always_comb begin
        o_rdata = '0;
        if (offset == GPIO_OFS_OUT) begin
            o_rdata[N_PINS-1:0] = gpio_out;
        end else if (offset == GPIO_OFS_IN) begin
            o_rdata[N_PINS-1:0] = i_ui_in;
        end else if (is_sel_reg) begin
            o_rdata[SEL_W-1:0] = func_sel[pin_idx];
        end
    end

    // Pin p takes bit p of the chosen source
    always_comb begin
        for (int p = 0; p < N_PINS; p++) begin
            if (func_sel[p].byte_bank) begin
                o_uo_out[p] = i_byte_pins[func_sel[p].slot][p];
            end else if (func_sel[p].slot == SLOT_GPIO) begin
                o_uo_out[p] = gpio_out[p];
            end else begin
                // Empty full slots drive nothing
                o_uo_out[p] = 1'b0;
            end
        end
    end

endmodule

//--- periph_addr_decode.sv
////////////////////
// Combinational address decode and read mux. Every source answers in
// the same cycle, so ready is high for any address.
////////////////////
`timescale 1ns/1ns

module periph_addr_decode (
    input  bus_pkg::bus_req_t                                        i_req,
    input  logic [bus_pkg::DATA_W-1:0]                               i_gpio_rdata,
    input  logic [periph_pkg::N_BYTE_SLOTS-1:0][bus_pkg::BYTE_W-1:0] i_byte_rdata,
    output logic                                                     o_gpio_sel,
    output logic [periph_pkg::N_BYTE_SLOTS-1:0]                      o_byte_sel,
    output logic [bus_pkg::DATA_W-1:0]                               o_rdata,
    output logic                                                     o_rready
);
    import bus_pkg::*;
    import periph_pkg::*;

    // One line per full slot, indexed by the 5-bit slot field
    logic [31:0] full_sel;
    logic        in_byte_region;

    assign in_byte_region = (i_req.addr.byte_v.region[2:1] == REGION_BYTE);

    always_comb begin
        full_sel   = '0;
        o_byte_sel = '0;
        o_rdata    = '0;
        o_rready   = 1'b0;

        if (in_byte_region) begin
            o_byte_sel[i_req.addr.byte_v.slot] = 1'b1;
            o_rdata  = {{(DATA_W-BYTE_W){1'b0}}, i_byte_rdata[i_req.addr.byte_v.slot]};
            o_rready = 1'b1;
        end else begin
            full_sel[i_req.addr.full_v.slot] = 1'b1;
            // Unpopulated full slots return zero but still complete
            if (full_sel[SLOT_GPIO]) begin
                o_rdata = i_gpio_rdata;
            end
            o_rready = 1'b1;
        end
    end

    assign o_gpio_sel = full_sel[SLOT_GPIO];

endmodule

//--- periph_asserts.sv
////////////////////
// Bus timing checks, bound into periph_top.
// The read strobe is assumed held until ready.
////////////////////
`timescale 1ns/1ns

module periph_asserts (
    input  logic                          clk,
    input  logic                          rst_n,
    input  bus_pkg::bus_req_t             i_req,
    input  logic                          i_data_read_complete,
    input  logic [bus_pkg::DATA_W-1:0]    o_data_out,
    input  logic                          o_data_ready,
    input  logic [periph_pkg::N_PINS-1:0] o_uo_out
);
    import bus_pkg::*;

    int unsigned fail_count = 0;

    // Every read is answered on the next edge
    read_ready_next: assert property (@(posedge clk) disable iff (!rst_n)
        (i_req.read_n != ACC_NONE) |=> o_data_ready)
        else begin
            fail_count++;
            $error("ready did not follow a read by one cycle");
        end

    // Held data must not move until the core completes the read
    data_held_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (o_data_ready && (i_req.read_n != ACC_NONE) && !i_data_read_complete)
        |=> $stable(o_data_out))
        else begin
            fail_count++;
            $error("read data changed while held");
        end

    pins_zero_in_reset: assert property (@(posedge clk)
        !rst_n |=> (o_uo_out == '0))
        else begin
            fail_count++;
            $error("output pins not zero in reset");
        end

endmodule

//--- periph_pkg.sv
////////////////////
// Peripheral map. Only full slot 1 (GPIO) is populated; the other full
// slots read as zero. Function selects lie at GPIO offset 0x20 + 4*pin.
////////////////////
package periph_pkg;

    localparam int unsigned N_PINS       = 8;
    localparam int unsigned N_BYTE_SLOTS = 16;

    localparam int unsigned SLOT_GPIO = 1;

    // GPIO register offsets within the 64-byte slot
    localparam logic [5:0] GPIO_OFS_OUT = 6'h00;
    localparam logic [5:0] GPIO_OFS_IN  = 6'h04;
    localparam logic [5:0] GPIO_OFS_SEL = 6'h20;

    // Bits of the offset that identify a function-select register
    localparam logic [5:0] GPIO_SEL_MASK = 6'h23;

    // Per-pin output source
    typedef struct packed {
        logic       spare;
        logic       byte_bank;
        logic [3:0] slot;
    } func_sel_t;

    localparam func_sel_t FUNC_SEL_GPIO = '{
        spare:     1'b0,
        byte_bank: 1'b0,
        slot:      4'(SLOT_GPIO)
    };

endpackage

//--- periph_read_port.sv
////////////////////
// Read data is registered and held until the core signals completion.
// Write acknowledge is combinational from the write strobe.
////////////////////
`timescale 1ns/1ns

module periph_read_port (
    input  logic                       clk,
    input  logic                       rst_n,
    input  bus_pkg::access_n_t         i_read,
    input  bus_pkg::access_n_t         i_write,
    input  logic [bus_pkg::DATA_W-1:0] i_rdata,
    input  logic                       i_rready,
    input  logic                       i_read_complete,
    output logic [bus_pkg::DATA_W-1:0] o_data,
    output logic                       o_ready
);
    import bus_pkg::*;

    logic              read_req;
    logic              hold;
    logic              ready_q;
    logic [DATA_W-1:0] data_q;

    assign read_req = (i_read != ACC_NONE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_q <= 1'b0;
            data_q  <= '0;
        end else begin
            ready_q <= read_req && i_rready;

            if (i_read_complete) begin
                hold <= 1'b0;
            end

            // Capture once per read; later edges keep the first value
            if (!hold && read_req && i_rready) begin
                hold   <= 1'b1;
                data_q <= i_rdata;
            end
        end
    end

    assign o_data  = data_q;
    assign o_ready = ready_q || (i_write != ACC_NONE);

endmodule

//--- periph_top.sv
////////////////////
// Peripheral wrapper. Reads return one cycle after the request and the
// core must hold the read strobe until it sees ready.
////////////////////
`timescale 1ns/1ns

module periph_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  bus_pkg::bus_req_t             i_req,
    input  logic [periph_pkg::N_PINS-1:0] i_ui_in,
    input  logic                          i_data_read_complete,
    output logic [bus_pkg::DATA_W-1:0]    o_data_out,
    output logic                          o_data_ready,
    output logic [periph_pkg::N_PINS-1:0] o_uo_out
);
    import bus_pkg::*;
    import periph_pkg::*;

    logic                                gpio_sel;
    logic [N_BYTE_SLOTS-1:0]             byte_sel;
    logic [DATA_W-1:0]                   gpio_rdata;
    logic [N_BYTE_SLOTS-1:0][BYTE_W-1:0] byte_rdata;
    logic [N_BYTE_SLOTS-1:0][N_PINS-1:0] byte_pins;
    logic [DATA_W-1:0]                   rdata;
    logic                                rready;

    periph_addr_decode u_decode (
        .i_req        (i_req),
        .i_gpio_rdata (gpio_rdata),
        .i_byte_rdata (byte_rdata),
        .o_gpio_sel   (gpio_sel),
        .o_byte_sel   (byte_sel),
        .o_rdata      (rdata),
        .o_rready     (rready)
    );

    periph_read_port u_read_port (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_read          (i_req.read_n),
        .i_write         (i_req.write_n),
        .i_rdata         (rdata),
        .i_rready        (rready),
        .i_read_complete (i_data_read_complete),
        .o_data          (o_data_out),
        .o_ready         (o_data_ready)
    );

    gpio_ctrl u_gpio (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_sel       (gpio_sel),
        .i_req       (i_req),
        .i_ui_in     (i_ui_in),
        .i_byte_pins (byte_pins),
        .o_rdata     (gpio_rdata),
        .o_uo_out    (o_uo_out)
    );

    byte_reg_bank u_byte_bank (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_sel   (byte_sel),
        .i_req   (i_req),
        .o_rdata (byte_rdata),
        .o_pins  (byte_pins)
    );

endmodule

//--- project.f
bus_pkg.sv
periph_pkg.sv
periph_addr_decode.sv
periph_read_port.sv
gpio_ctrl.sv
byte_reg_bank.sv
periph_top.sv
periph_asserts.sv
tb_periph_top.sv

//--- tb_periph_top.sv
////////////////////
// Directed testbench for periph_top.
// All accesses are word sized; one bus access at a time.
////////////////////
`timescale 1ns/1ns

module tb_periph_top;
    import bus_pkg::*;
    import periph_pkg::*;

    localparam int TIMEOUT = 100;

    logic                 clk;
    logic                 rst_n;
    bus_req_t             req;
    logic [N_PINS-1:0]    ui_in;
    logic                 read_complete;
    logic [DATA_W-1:0]    data_out;
    logic                 data_ready;
    logic [N_PINS-1:0]    uo_out;
    integer               seed;
    logic [N_PINS-1:0]    gpio_val;

    periph_top DUT (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_req                (req),
        .i_ui_in              (ui_in),
        .i_data_read_complete (read_complete),
        .o_data_out           (data_out),
        .o_data_ready         (data_ready),
        .o_uo_out             (uo_out)
    );

    bind periph_top periph_asserts u_asserts (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_req                (i_req),
        .i_data_read_complete (i_data_read_complete),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready),
        .o_uo_out             (o_uo_out)
    );

    always #5 clk = ~clk;

    // A failed bus timing assertion ends the run
    always @(posedge clk) begin
        if (DUT.u_asserts.fail_count != 0) begin
            $display("Test failed");
            $fatal(1, "Bus timing assertion failed");
        end
    end

    task automatic fail_timeout(input string what);
        $display("Test failed");
        $fatal(1, "Timeout while waiting for %s", what);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, exp, act);
            $display("Test failed");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
        int waited;
        @(negedge clk);
        req.addr    = periph_addr_u'(addr);
        req.wdata   = data;
        req.write_n = ACC_WORD;
        waited = 0;
        #1;
        while (!data_ready) begin
            if (waited > TIMEOUT) fail_timeout("write acknowledge");
            #1;
            waited++;
        end
        // Write commits on the edge before this one
        @(negedge clk);
        req.write_n = ACC_NONE;
    endtask

    // Raise the read strobe and count cycles until ready
    task automatic read_start(input logic [ADDR_W-1:0] addr, output int latency);
        @(negedge clk);
        req.addr   = periph_addr_u'(addr);
        req.read_n = ACC_WORD;
        latency = 0;
        do begin
            @(negedge clk);
            latency++;
            if (latency > TIMEOUT) fail_timeout("read ready");
        end while (!data_ready);
    endtask

    task automatic read_finish();
        req.read_n    = ACC_NONE;
        read_complete = 1'b1;
        @(negedge clk);
        read_complete = 1'b0;
    endtask

    task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [31:0] data);
        int latency;
        read_start(addr, latency);
        data = data_out;
        read_finish();
    endtask

    task automatic test_reset();
        logic [31:0] rd;
        check_value("reset pins", 32'h0, {24'h0, uo_out});
        for (int p = 0; p < N_PINS; p++) begin
            bus_read(11'h060 + 11'(4 * p), rd);
            check_value("reset func select", 32'h1, rd);
        end
    endtask

    task automatic test_gpio_out();
        logic [31:0] rd;
        gpio_val = 8'($random(seed));
        bus_write(11'h040, {24'h0, gpio_val});
        bus_read(11'h040, rd);
        check_value("gpio out readback", {24'h0, gpio_val}, rd);
        check_value("gpio out pins", {24'h0, gpio_val}, {24'h0, uo_out});
    endtask

    task automatic test_gpio_in();
        logic [31:0] rd;
        @(negedge clk);
        ui_in = 8'($random(seed));
        bus_read(11'h044, rd);
        check_value("gpio input", {24'h0, ui_in}, rd);
    endtask

    task automatic test_byte_slots();
        logic [31:0] rd;
        logic [7:0]  val;
        logic [7:0]  exp_pins;
        int          k;
        int          p;
        for (int n = 0; n < 4; n++) begin
            k   = ($random(seed) & 32'hf);
            p   = ($random(seed) & 32'h7);
            val = 8'($random(seed));
            // Routed bit differs from the GPIO bit it replaces
            val[p] = ~gpio_val[p];
            bus_write(11'h400 + 11'(16 * k), $random(seed) & 32'hffff_ff00 | val);
            bus_read(11'h400 + 11'(16 * k), rd);
            check_value("byte slot readback", {24'h0, val}, rd);
            // Route pin p to byte slot k
            bus_write(11'h060 + 11'(4 * p), 32'h10 | k);
            exp_pins    = gpio_val;
            exp_pins[p] = val[p];
            check_value("byte slot pin routing", {24'h0, exp_pins}, {24'h0, uo_out});
            bus_write(11'h060 + 11'(4 * p), 32'h1);
            check_value("pin back to gpio", {24'h0, gpio_val}, {24'h0, uo_out});
        end
    endtask

    task automatic test_unmapped_hold();
        logic [31:0] rd;
        int          latency;
        bus_write(11'h430, 32'h0000_00a5);
        bus_read(11'h430, rd);
        check_value("hold source readback", 32'h0000_00a5, rd);
        read_start(11'h140, latency);
        check_value("unmapped latency", 32'd1, latency);
        check_value("unmapped data", 32'h0, data_out);
        // New address while the first result is still held
        req.addr = periph_addr_u'(11'h430);
        repeat (2) @(negedge clk);
        check_value("held data", 32'h0, data_out);
        read_finish();
    endtask

    initial begin
        seed          = 32'h9f22_7f7a;
        clk           = 1'b0;
        rst_n         = 1'b0;
        req.addr      = '0;
        req.wdata     = '0;
        req.write_n   = ACC_NONE;
        req.read_n    = ACC_NONE;
        ui_in         = '0;
        read_complete = 1'b0;
        gpio_val      = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset();
        test_gpio_out();
        test_gpio_in();
        test_byte_slots();
        test_unmapped_hold();

        if (DUT.u_asserts.fail_count == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "Bus timing assertion failed");
        end
    end

endmodule
